// ==== sim/mmu_stimulus.txt ====
# test: name load wt_base in_base run_rows out_base, all hex; load 0 keeps the array weights
# w: W(k,c) for k = 0..3 then c = 0..3, weight row k is written at wt_base + k
# r: A(r,0..3) then C(r,0..3) = sum over k of A(r,k)*W(k,c) mod 2^16
test identity 1 0 0 4 0
w 01 00 00 00  00 01 00 00  00 00 01 00  00 00 00 01
r 01 02 03 04  0001 0002 0003 0004
r 10 20 30 40  0010 0020 0030 0040
r ff 80 7f 00  00ff 0080 007f 0000
r a5 5a 3c c3  00a5 005a 003c 00c3
test product 1 5 4 4 4
w 01 02 00 ff  03 00 01 ff  00 04 02 ff  05 01 03 ff
r 01 02 03 04  001b 0012 0014 09f6
r ff ff ff ff  08f7 06f9 05fa f804
r 10 00 20 02  001a 00a2 0046 31ce
r 80 40 c0 ff  063b 04ff 04bd 7c81
# weights stay from the product test, this w record only repeats them
test retain 0 5 8 8 6
w 01 02 00 ff  03 00 01 ff  00 04 02 ff  05 01 03 ff
r 00 00 00 00  0000 0000 0000 0000
r 01 00 00 00  0001 0002 0000 00ff
r 00 01 00 00  0003 0000 0001 00ff
r 00 00 01 00  0000 0004 0002 00ff
r 00 00 00 01  0005 0001 0003 00ff
r 02 03 04 05  0024 0019 001a 0df2
r ff 00 ff 00  00ff 05fa 01fe fc02
r 64 c8 0a 32  03b6 0122 0172 6698

// ==== tb.f ====
hdl/mmu_pkg.sv
hdl/mac_pe.sv
hdl/systolic_array.sv
hdl/input_side.sv
hdl/weight_loader.sv
hdl/output_side.sv
hdl/mmu_top.sv
sim/tb_mmu.sv

// ==== Makefile ====
TOP = tb_mmu

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== sim/tb_mmu.sv ====
`timescale 1ns/1ps

module tb_mmu;
    import mmu_pkg::*;

    localparam int MAX_ROWS  = 8;
    localparam int N_TESTS   = 3;
    // per test: load, skew in and out, row stream, host traffic; doubled for margin
    localparam int CYC_LIMIT = N_TESTS * (2*ARR_N + 8 + MAX_ROWS + 40) * 2;

    logic              clk;
    logic              rst_n;
    mem_wr_t           in_wr;
    mem_wr_t           wt_wr;
    logic              load_req;
    logic              load_ack;
    logic [ADDR_W-1:0] wt_base;
    logic              run_req;
    logic              run_ack;
    logic [ADDR_W-1:0] in_base;
    logic [ADDR_W-1:0] out_base;
    logic [ADDR_W-1:0] run_rows;
    logic [ADDR_W-1:0] out_rd_addr;
    res_row_t          out_rd_data;

    int                cycles = 0;            // timeout counter
    int                seed;
    int                fd;
    int                n_pass;
    int                n_fail;
    int                test_errs;
    logic [127:0]      name;                  // current test name
    logic              do_load;
    logic [ADDR_W-1:0] t_wt_base;
    logic [ADDR_W-1:0] t_in_base;
    logic [ADDR_W-1:0] t_rows;
    logic [ADDR_W-1:0] t_out_base;
    logic [DATA_W-1:0] w_tile [ARR_N][ARR_N];       // W(k,c)
    logic [DATA_W-1:0] a_rows [MAX_ROWS][ARR_N];    // A(r,k)
    logic [ACC_W-1:0]  c_rows [MAX_ROWS][ARR_N];    // expected C(r,c)
    res_row_t          exp_mem [2**ADDR_W];         // model of output memory
    logic              exp_vld [2**ADDR_W];         // row written at least once

    mmu_top i_mmu_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_wr       (in_wr),
        .wt_wr       (wt_wr),
        .load_req    (load_req),
        .load_ack    (load_ack),
        .wt_base     (wt_base),
        .run_req     (run_req),
        .run_ack     (run_ack),
        .in_base     (in_base),
        .out_base    (out_base),
        .run_rows    (run_rows),
        .out_rd_addr (out_rd_addr),
        .out_rd_data (out_rd_data)
    );

    always #10 clk = ~clk;                    // 20 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYC_LIMIT) begin
            $display("timeout: no handshake completed within %0d cycles", CYC_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ====================
    // helpers
    // ====================
    task automatic step_cycle();
        @(posedge clk);
        #2;                                   // drive and sample off the edge
    endtask

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0s: %0s expected %h actual %h", name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = ($random(seed) & 32'h3) + 1;    // 1 to 4 idle cycles
        repeat (gap) begin
            step_cycle();
            check_val("load_ack while idle", 64'(1'b0), 64'(load_ack));
            check_val("run_ack while idle", 64'(1'b0), 64'(run_ack));
        end
    endtask

    task automatic report_test();
        if (test_errs == 0) begin
            n_pass++;
            $display("test %0s: pass", name);
        end else begin
            n_fail++;
            $display("test %0s: fail with %0d errors", name, test_errs);
        end
    endtask

    // ====================
    // stimulus file
    // ====================
    task automatic read_tag(output logic [63:0] tag);
        int c;
        int n;
        n = $fscanf(fd, "%s", tag);
        while (n == 1 && tag == "#") begin    // comment line, skip the rest
            c = $fgetc(fd);
            while (c != "\n" && c != -1) begin
                c = $fgetc(fd);
            end
            n = $fscanf(fd, "%s", tag);
        end
        if (n != 1) begin
            tag = "eof";
        end
    endtask

    task automatic read_test(output bit ok);
        logic [63:0] tag;
        int          n;
        ok = 1'b1;
        n  = $fscanf(fd, "%s %h %h %h %h %h", name, do_load, t_wt_base, t_in_base,
                     t_rows, t_out_base);
        if (n != 6 || t_rows == 0 || t_rows > MAX_ROWS) begin
            ok = 1'b0;
        end
        read_tag(tag);
        if (tag != "w") begin
            ok = 1'b0;
        end
        for (int k = 0; k < ARR_N; k++) begin
            for (int c = 0; c < ARR_N; c++) begin
                n = $fscanf(fd, "%h", w_tile[k][c]);
            end
        end
        if (ok) begin
            for (int r = 0; r < int'(t_rows); r++) begin
                read_tag(tag);
                if (tag != "r") begin
                    ok = 1'b0;
                end
                for (int k = 0; k < ARR_N; k++) begin
                    n = $fscanf(fd, "%h", a_rows[r][k]);
                end
                for (int c = 0; c < ARR_N; c++) begin
                    n = $fscanf(fd, "%h", c_rows[r][c]);
                    if (n != 1) begin
                        ok = 1'b0;
                    end
                end
            end
        end
    endtask

    // ====================
    // host operations
    // ====================
    task automatic write_weights();
        for (int k = 0; k < ARR_N; k++) begin
            wt_wr.en   = 1'b1;
            wt_wr.addr = t_wt_base + ADDR_W'(k);     // tile row k
            for (int c = 0; c < ARR_N; c++) begin
                wt_wr.data[c] = w_tile[k][c];
            end
            step_cycle();
        end
        wt_wr = '0;
    endtask

    task automatic write_inputs();
        for (int r = 0; r < int'(t_rows); r++) begin
            in_wr.en   = 1'b1;
            in_wr.addr = t_in_base + ADDR_W'(r);
            for (int k = 0; k < ARR_N; k++) begin
                in_wr.data[k] = a_rows[r][k];
            end
            step_cycle();
        end
        in_wr = '0;
    endtask

    task automatic load_weights();
        int lat;
        check_val("load_ack before req", 64'(1'b0), 64'(load_ack));
        load_req = 1'b1;
        lat      = 0;
        do begin
            step_cycle();
            lat++;
        end while (!load_ack);                    // bounded by the timeout
        check_val("load latency", 64'(ARR_N + 2), 64'(lat));   // detect, shift, commit
        repeat (2) begin
            step_cycle();
            check_val("load_ack while req high", 64'(1'b1), 64'(load_ack));
        end
        load_req = 1'b0;
        step_cycle();
        check_val("load_ack after req drop", 64'(1'b0), 64'(load_ack));
    endtask

    task automatic run_tile();
        check_val("run_ack before req", 64'(1'b0), 64'(run_ack));
        run_req = 1'b1;
        do begin
            step_cycle();
        end while (!run_ack);
        repeat (2) begin
            step_cycle();
            check_val("run_ack while req high", 64'(1'b1), 64'(run_ack));
        end
        run_req = 1'b0;
        step_cycle();
        check_val("run_ack after req drop", 64'(1'b0), 64'(run_ack));
    endtask

    task automatic check_out_mem();
        for (int a = 0; a < 2**ADDR_W; a++) begin
            if (exp_vld[a]) begin                  // only rows written so far
                out_rd_addr = ADDR_W'(a);
                step_cycle();                      // one cycle read
                check_val($sformatf("out row %0d", a), exp_mem[a], out_rd_data);
            end
        end
    endtask

    task automatic run_test();
        logic [ADDR_W-1:0] idx;
        test_errs = 0;
        wt_base   = t_wt_base;
        in_base   = t_in_base;
        out_base  = t_out_base;
        run_rows  = t_rows;
        if (do_load) begin                         // load 0 keeps the array weights
            write_weights();
            idle_gap();
            load_weights();
        end
        write_inputs();
        idle_gap();
        run_tile();
        for (int r = 0; r < int'(t_rows); r++) begin
            idx = t_out_base + ADDR_W'(r);
            for (int c = 0; c < ARR_N; c++) begin
                exp_mem[idx][c] = c_rows[r][c];
            end
            exp_vld[idx] = 1'b1;
        end
        check_out_mem();                           // new rows and untouched old ones
        report_test();
    endtask

    // ====================
    // main
    // ====================
    initial begin
        logic [63:0] tag;
        bit          ok;
        bit          file_end;
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_wr       = '0;
        wt_wr       = '0;
        load_req    = 1'b0;
        wt_base     = '0;
        run_req     = 1'b0;
        in_base     = '0;
        out_base    = '0;
        run_rows    = '0;
        out_rd_addr = '0;
        seed        = 32'hb2d9;
        n_pass      = 0;
        n_fail      = 0;
        file_end    = 1'b0;
        for (int a = 0; a < 2**ADDR_W; a++) begin
            exp_vld[a] = 1'b0;
        end
        fd = $fopen("sim/mmu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/mmu_stimulus.txt");
            n_fail++;
        end else begin
            repeat (8) @(posedge clk);
            #2;
            rst_n     = 1'b1;
            name      = "reset";
            test_errs = 0;
            check_val("load_ack after reset", 64'(1'b0), 64'(load_ack));
            check_val("run_ack after reset", 64'(1'b0), 64'(run_ack));
            idle_gap();
            report_test();
            while (!file_end) begin
                read_tag(tag);
                if (tag == "eof") begin
                    file_end = 1'b1;
                end else if (tag != "test") begin
                    $display("stimulus file has a record out of place");
                    n_fail++;
                    file_end = 1'b1;
                end else begin
                    read_test(ok);
                    if (ok) begin
                        run_test();
                    end else begin
                        $display("stimulus file has a malformed test record");
                        n_fail++;
                        file_end = 1'b1;
                    end
                end
            end
            $fclose(fd);
        end
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mmu_pkg::mem_wr_t           in_wr,
    input  mmu_pkg::mem_wr_t           wt_wr,
    input  logic                       load_req,
    output logic                       load_ack,
    input  logic [mmu_pkg::ADDR_W-1:0] wt_base,
    input  logic                       run_req,
    output logic                       run_ack,
    input  logic [mmu_pkg::ADDR_W-1:0] in_base,
    input  logic [mmu_pkg::ADDR_W-1:0] out_base,
    input  logic [mmu_pkg::ADDR_W-1:0] run_rows,
    input  logic [mmu_pkg::ADDR_W-1:0] out_rd_addr,
    output mmu_pkg::res_row_t          out_rd_data
);
    import mmu_pkg::*;

    row_t     w_shift;
    logic     w_load;
    row_t     a_in;
    logic     a_valid;
    res_row_t sum_out;
    logic     out_start;
    logic     done;
    logic     done_q;                       // for done rising edge
    logic     run_busy;
    logic     run_go;
    logic     load_go;                      // load_req as the loader sees it

    // ====================
    // run handshake
    // ====================
    // start once per req and not while a weight load handshake is open
    assign run_go = run_req && !run_busy && !run_ack && !load_req && !load_ack;

    // a load request waits until the run in progress has finished
    assign load_go = load_req && !run_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_busy <= 1'b0;
            run_ack  <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= done;
            if (run_go) begin
                run_busy <= 1'b1;
            end else if (run_busy && done && !done_q) begin  // fresh done only
                run_busy <= 1'b0;
                run_ack  <= 1'b1;
            end else if (run_ack && !run_req) begin
                run_ack <= 1'b0;                              // four-phase return
            end
        end
    end

    // ====================
    // sides and array
    // ====================
    input_side i_input_side (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_wr     (in_wr),                  // host write port
        .run_go    (run_go),
        .in_base   (in_base),
        .run_rows  (run_rows),
        .a_in      (a_in),                   // skewed lanes to array
        .a_valid   (a_valid),
        .out_start (out_start)               // to output side
    );

    weight_loader i_weight_loader (
        .clk      (clk),
        .rst_n    (rst_n),
        .wt_wr    (wt_wr),
        .load_req (load_go),
        .wt_base  (wt_base),
        .load_ack (load_ack),
        .w_shift  (w_shift),
        .w_load   (w_load)
    );

    systolic_array i_systolic_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .w_shift (w_shift),
        .w_load  (w_load),
        .a_in    (a_in),
        .a_valid (a_valid),
        .sum_out (sum_out)                   // skewed per column
    );

    output_side i_output_side (
        .clk         (clk),
        .rst_n       (rst_n),
        .out_start   (out_start),
        .run_rows    (run_rows),
        .out_base    (out_base),
        .sum_out     (sum_out),
        .out_rd_addr (out_rd_addr),          // host read port
        .out_rd_data (out_rd_data),
        .done        (done)
    );

endmodule

// ==== hdl/output_side.sv ====
`timescale 1ns/1ps

module output_side (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       out_start,
    input  logic [mmu_pkg::ADDR_W-1:0] run_rows,
    input  logic [mmu_pkg::ADDR_W-1:0] out_base,
    input  mmu_pkg::res_row_t          sum_out,
    input  logic [mmu_pkg::ADDR_W-1:0] out_rd_addr,
    output mmu_pkg::res_row_t          out_rd_data,
    output logic                       done
);
    import mmu_pkg::*;

    res_row_t          out_mem [2**ADDR_W];  // output memory
    res_row_t          hist [ARR_N-1];       // past array rows with [j] j+1 cycles old
    res_row_t          aligned;              // deskewed result row
    res_wr_t           res_wr;
    logic              active;
    logic [ADDR_W:0]   cyc;                  // cycles since out_start
    logic [ADDR_W:0]   end_cyc;              // first cycle past the last row
    logic [ADDR_W-1:0] rows_q;

    // ====================
    // deskew
    // ====================
    always_ff @(posedge clk) begin
        hist[0] <= sum_out;
        for (int j = 1; j < ARR_N-1; j++) begin
            hist[j] <= hist[j-1];
        end
    end

    // column c leaves the array c cycles late so hold it ARR_N-1-c more
    for (genvar c = 0; c < ARR_N; c++) begin : g_deskew
        if (c == ARR_N-1) begin : g_now
            assign aligned[c] = sum_out[c];
        end else begin : g_old
            assign aligned[c] = hist[ARR_N-2-c][c];
        end
    end

    // ====================
    // write controller
    // ====================
    assign end_cyc = (ADDR_W+1)'(OUT_LAT) + {1'b0, rows_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            cyc    <= '0;
            rows_q <= '0;
            done   <= 1'b0;
            res_wr <= '0;
        end else begin
            if (out_start) begin
                active <= 1'b1;
                cyc    <= (ADDR_W+1)'(1);        // cycle after the pulse
                rows_q <= run_rows;
                done   <= 1'b0;                  // new run clears done
            end else if (active) begin
                cyc <= cyc + 1'b1;
                if (cyc == end_cyc) begin        // last row written at this edge
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
            res_wr.en   <= active && (cyc >= (ADDR_W+1)'(OUT_LAT)) && (cyc < end_cyc);
            res_wr.addr <= out_base + ADDR_W'(cyc - OUT_LAT);  // base + row
            res_wr.data <= aligned;
        end
    end

    // ====================
    // memory
    // ====================
    always_ff @(posedge clk) begin
        if (res_wr.en) begin
            out_mem[res_wr.addr] <= res_wr.data;
        end
        out_rd_data <= out_mem[out_rd_addr];     // host read in one cycle
    end

endmodule

// ==== hdl/weight_loader.sv ====
`timescale 1ns/1ps

module weight_loader (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mmu_pkg::mem_wr_t           wt_wr,
    input  logic                       load_req,
    input  logic [mmu_pkg::ADDR_W-1:0] wt_base,
    output logic                       load_ack,
    output mmu_pkg::row_t              w_shift,
    output logic                       w_load
);
    import mmu_pkg::*;

    row_t              wt_mem [2**ADDR_W];  // weight memory
    ld_state_t         state;
    logic [ADDR_W-1:0] cnt;                 // shift cycle
    logic [ADDR_W-1:0] rd_addr;

    always_ff @(posedge clk) begin
        if (wt_wr.en) begin
            wt_mem[wt_wr.addr] <= wt_wr.data;    // host write
        end
    end

    // last tile row goes in first so row k lands in cell row k
    assign rd_addr = wt_base + ADDR_W'(ARR_N - 1) - cnt;
    assign w_shift = (state == LD_SHIFT) ? wt_mem[rd_addr] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= LD_IDLE;
            cnt      <= '0;
            w_load   <= 1'b0;
            load_ack <= 1'b0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (load_req) begin                  // detect cycle
                        state <= LD_SHIFT;
                        cnt   <= '0;
                    end
                end
                LD_SHIFT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == ADDR_W'(ARR_N - 1)) begin // chain full
                        state  <= LD_DONE;
                        w_load <= 1'b1;
                    end
                end
                LD_DONE: begin
                    if (!load_ack) begin
                        w_load   <= 1'b0;                // commit cycle
                        load_ack <= 1'b1;
                    end else if (!load_req) begin
                        load_ack <= 1'b0;                // four-phase return
                        state    <= LD_IDLE;
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/input_side.sv ====
`timescale 1ns/1ps

module input_side (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mmu_pkg::mem_wr_t           in_wr,
    input  logic                       run_go,
    input  logic [mmu_pkg::ADDR_W-1:0] in_base,
    input  logic [mmu_pkg::ADDR_W-1:0] run_rows,
    output mmu_pkg::row_t              a_in,
    output logic                       a_valid,
    output logic                       out_start
);
    import mmu_pkg::*;

    row_t              in_mem [2**ADDR_W];  // input memory
    rd_state_t         state;
    logic [ADDR_W-1:0] cnt;                 // row count, then drain count
    row_t              rd_row;              // registered read data

    // ====================
    // memory
    // ====================
    always_ff @(posedge clk) begin
        if (in_wr.en) begin
            in_mem[in_wr.addr] <= in_wr.data;    // host write
        end
        rd_row <= in_mem[in_base + cnt];         // sync read at base + row
    end

    // ====================
    // read controller
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RD_IDLE;
            cnt       <= '0;
            a_valid   <= 1'b0;
            out_start <= 1'b0;
        end else begin
            a_valid   <= (state == RD_STREAM);                 // lines up with rd_row
            out_start <= (state == RD_STREAM) && (cnt == '0);  // first read only
            case (state)
                RD_IDLE: begin
                    if (run_go) begin
                        state <= RD_STREAM;
                        cnt   <= '0;
                    end
                end
                RD_STREAM: begin
                    if (cnt == run_rows - 1'b1) begin            // last row read
                        state <= RD_DRAIN;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RD_DRAIN: begin
                    if (cnt == ADDR_W'(ARR_N - 2)) begin         // skew regs flushed
                        state <= RD_DONE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RD_DONE:  state <= RD_IDLE;
                default:  state <= RD_IDLE;
            endcase
        end
    end

    // lane k delayed by k cycles
    for (genvar k = 0; k < ARR_N; k++) begin : g_lane
        if (k == 0) begin : g_direct
            assign a_in[k] = rd_row[k];                  // no skew on lane 0
        end else begin : g_skew
            logic [DATA_W-1:0] pipe [k];                 // k stage delay line

            always_ff @(posedge clk) begin
                pipe[0] <= rd_row[k];
                for (int j = 1; j < k; j++) begin
                    pipe[j] <= pipe[j-1];
                end
            end
            assign a_in[k] = pipe[k-1];
        end
    end

endmodule

// ==== hdl/systolic_array.sv ====
`timescale 1ns/1ps

module systolic_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mmu_pkg::row_t         w_shift,
    input  logic                  w_load,
    input  mmu_pkg::row_t         a_in,
    input  logic                  a_valid,
    output mmu_pkg::res_row_t     sum_out
);
    import mmu_pkg::*;

    // bus [r][c] feeds cell (r,c); the extra slot is the edge output
    logic [DATA_W-1:0] w_bus [ARR_N+1][ARR_N];   // weights, down
    logic [DATA_W-1:0] a_bus [ARR_N][ARR_N+1];   // activations, right
    logic              v_bus [ARR_N][ARR_N+1];   // valids, right
    logic [ACC_W-1:0]  s_bus [ARR_N+1][ARR_N];   // partial sums, down
    logic [ARR_N-2:0]  vld_sr;                   // valid skew chain
    logic [ARR_N-1:0]  row_vld;

    // row r valid trails row 0 by r cycles, same as its data lane
    assign row_vld = {vld_sr, a_valid};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= row_vld[ARR_N-2:0];
        end
    end

    for (genvar c = 0; c < ARR_N; c++) begin : g_edge_col
        assign w_bus[0][c] = w_shift[c];        // top of each column
        assign s_bus[0][c] = '0;                // sums start at zero
        assign sum_out[c]  = s_bus[ARR_N][c];   // bottom row out, skewed by c
    end

    for (genvar r = 0; r < ARR_N; r++) begin : g_row
        assign a_bus[r][0] = a_in[r];           // left of each row
        assign v_bus[r][0] = row_vld[r];

        for (genvar c = 0; c < ARR_N; c++) begin : g_col
            mac_pe i_mac_pe (
                .clk         (clk),
                .rst_n       (rst_n),
                .w_shift_in  (w_bus[r][c]),
                .w_load      (w_load),
                .a_in        (a_bus[r][c]),
                .a_valid_in  (v_bus[r][c]),
                .sum_in      (s_bus[r][c]),
                .w_shift_out (w_bus[r+1][c]),
                .a_out       (a_bus[r][c+1]),
                .a_valid_out (v_bus[r][c+1]),
                .sum_out     (s_bus[r+1][c])
            );
        end
    end

endmodule

// ==== hdl/mac_pe.sv ====
`timescale 1ns/1ps

module mac_pe (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [mmu_pkg::DATA_W-1:0] w_shift_in,
    input  logic                       w_load,
    input  logic [mmu_pkg::DATA_W-1:0] a_in,
    input  logic                       a_valid_in,
    input  logic [mmu_pkg::ACC_W-1:0]  sum_in,
    output logic [mmu_pkg::DATA_W-1:0] w_shift_out,
    output logic [mmu_pkg::DATA_W-1:0] a_out,
    output logic                       a_valid_out,
    output logic [mmu_pkg::ACC_W-1:0]  sum_out
);
    import mmu_pkg::*;

    logic [DATA_W-1:0] weight;              // stationary weight
    logic [ACC_W-1:0]  product;

    assign product = ACC_W'(a_in) * ACC_W'(weight);   // unsigned, wraps at 16 bits

    always_ff @(posedge clk) begin
        w_shift_out <= w_shift_in;          // weight shift chain, free running
        if (w_load) begin
            weight <= w_shift_out;          // take what the chain holds now
        end
        a_out <= a_in;                      // activation moves right
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_valid_out <= 1'b0;
            sum_out     <= '0;
        end else begin
            a_valid_out <= a_valid_in;
            sum_out     <= a_valid_in ? sum_in + product : sum_in;  // accumulate down
        end
    end

endmodule

// ==== hdl/mmu_pkg.sv ====
package mmu_pkg;

    // ====================
    // sizes
    // ====================
    localparam int ARR_N   = 4;             // array side, tile rows and cols
    localparam int DATA_W  = 8;             // activation / weight width
    localparam int ACC_W   = 16;            // result width, truncated
    localparam int ADDR_W  = 4;             // 16 rows per memory
    localparam int OUT_LAT = 2*ARR_N - 1;   // out_start to first aligned result row

    // ====================
    // port structs
    // ====================
    typedef logic [ARR_N-1:0][DATA_W-1:0] row_t;       // lane k in [k]
    typedef logic [ARR_N-1:0][ACC_W-1:0]  res_row_t;   // column c in [c]

    typedef struct packed {
        logic              en;              // one row per cycle
        logic [ADDR_W-1:0] addr;
        row_t              data;
    } mem_wr_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;            // out_base + row
        res_row_t          data;
    } res_wr_t;

    // ====================
    // controller states
    // ====================
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_SHIFT,
        LD_DONE
    } ld_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_STREAM,
        RD_DRAIN,
        RD_DONE
    } rd_state_t;

endpackage
